/* logic/cpu_pkg.sv */
package cpu_pkg;

  //////////////////////////////////////////////////
  // Word types
  //////////////////////////////////////////////////
  typedef logic [15:0] pc_t;    // Word address
  typedef logic [15:0] inst_t;  // One instruction word

  // Saturating counter whose MSB gives the taken guess
  typedef logic [1:0] pred_t;

  localparam pred_t PRED_STRONG_NOT_TAKEN = 2'b00;  // Floor of the counter
  localparam pred_t PRED_WEAK_TAKEN       = 2'b10;  // Fresh entries start here
  localparam pred_t PRED_STRONG_TAKEN     = 2'b11;  // Ceiling of the counter

  // Bubble that a flush leaves in IF/ID
  localparam inst_t NOP_INST = 16'h0000;

  //////////////////////////////////////////////////
  // BTB storage
  //////////////////////////////////////////////////
  typedef struct packed {
    logic  valid;    // Entry holds a trained branch
    pc_t   tag;      // PC bits above the index, right aligned
    pc_t   target;   // Last taken destination
    pred_t counter;  // Direction history
  } btb_entry_t;

endpackage

/* logic/axi_pkg.sv */
package axi_pkg;

  localparam int AXI_DATA_W = 32;  // Two instructions per beat

  // Read response codes
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'b00;

  // arprot bits are {instruction, non-secure, privileged}
  typedef logic [2:0] prot_t;
  localparam prot_t AXI_PROT_INSN = 3'b100;  // Unprivileged secure fetch

endpackage

/* logic/fetch_if.sv */
interface fetch_if;
  import cpu_pkg::*;

  pc_t   pc_curr;           // PC of the word in flight
  pc_t   pc_next;           // Successor picked by the sequencer
  inst_t inst;              // Word read from the cache
  logic  hit;               // Cache had the word
  logic  btb_match;         // BTB tag compare
  pred_t prediction;        // Counter of the matching entry
  pc_t   predicted_target;  // Target of the matching entry

  // Sequencer, cache and BTB each drive their own fields
  modport fetch_src (
    output pc_curr, pc_next, inst, hit, btb_match, prediction, predicted_target
  );

  // IF/ID register samples the whole bundle
  modport fetch_dst (
    input pc_curr, pc_next, inst, hit, btb_match, prediction, predicted_target
  );
endinterface

/* logic/pc_sequencer.sv */
module pc_sequencer #(
  parameter cpu_pkg::pc_t RESET_PC = '0
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         stall,           // Decode back-pressure
  input  logic         miss_busy,       // Cache has no word for this PC yet
  input  logic         redirect_valid,  // Mispredict or exception from later stages
  input  cpu_pkg::pc_t redirect_pc,
  fetch_if.fetch_src   fetch,           // pc_curr and pc_next only
  output cpu_pkg::pc_t pc               // Lookup address for cache and BTB
);
  import cpu_pkg::*;

  pc_t  pc_q;       // Architectural fetch PC
  pc_t  pc_succ;    // Where fetch goes after this word
  logic take_pred;  // BTB says jump
  logic advance;    // Word accepted this cycle

  // Trust the BTB only on a tag match with a taken counter
  assign take_pred = fetch.btb_match & fetch.prediction[1];
  assign pc_succ   = take_pred ? fetch.predicted_target : pc_q + 16'd1;
  assign advance   = ~stall & ~miss_busy;

  assign pc            = pc_q;
  assign fetch.pc_curr = pc_q;
  assign fetch.pc_next = pc_succ;  // Travels down the pipe for branch checking

  //////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_valid) begin
      pc_q <= redirect_pc;  // Wins over stall and miss
    end else if (advance) begin
      pc_q <= pc_succ;
    end
  end

  // A refill must see the same PC when it completes
  a_pc_hold_on_miss: assert property (
    @(posedge clk) disable iff (!rst_n)
    miss_busy && !redirect_valid |=> $stable(pc_q)
  ) else $error("Fetch PC moved while the cache was refilling");

endmodule

/* logic/branch_target_buffer.sv */
module branch_target_buffer #(
  parameter int BTB_ENTRIES = 8
) (
  input  logic         clk,
  input  logic         rst_n,
  input  cpu_pkg::pc_t lookup_pc,   // Current fetch PC
  fetch_if.fetch_src   fetch,       // btb_match, prediction and predicted_target
  input  logic         upd_valid,   // Branch resolved in execute
  input  cpu_pkg::pc_t upd_pc,
  input  logic         upd_taken,
  input  cpu_pkg::pc_t upd_target
);
  import cpu_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);

  btb_entry_t       table_q [BTB_ENTRIES];
  logic [IDX_W-1:0] rd_idx;
  pc_t              rd_tag;
  btb_entry_t       rd_entry;
  logic             rd_match;
  logic [IDX_W-1:0] wr_idx;
  pc_t              wr_tag;
  btb_entry_t       wr_entry;
  logic             wr_match;

  //////////////////////////////////////////////////
  // Lookup port
  //////////////////////////////////////////////////
  assign rd_idx   = lookup_pc[IDX_W-1:0];   // Low bits pick the set
  assign rd_tag   = lookup_pc >> IDX_W;     // Rest is compared
  assign rd_entry = table_q[rd_idx];
  assign rd_match = rd_entry.valid && (rd_entry.tag == rd_tag);

  // Quiet outputs on a miss so nothing stale leaks out
  assign fetch.btb_match        = rd_match;
  assign fetch.prediction       = rd_match ? rd_entry.counter : PRED_STRONG_NOT_TAKEN;
  assign fetch.predicted_target = rd_match ? rd_entry.target : '0;

  //////////////////////////////////////////////////
  // Update port
  //////////////////////////////////////////////////
  assign wr_idx   = upd_pc[IDX_W-1:0];
  assign wr_tag   = upd_pc >> IDX_W;
  assign wr_entry = table_q[wr_idx];
  assign wr_match = wr_entry.valid && (wr_entry.tag == wr_tag);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        table_q[i] <= '0;
      end
    end else if (upd_valid) begin
      if (wr_match) begin
        if (upd_taken) begin
          table_q[wr_idx].target <= upd_target;  // Indirect targets can move
          if (wr_entry.counter != PRED_STRONG_TAKEN) begin
            table_q[wr_idx].counter <= wr_entry.counter + 2'd1;
          end
        end else if (wr_entry.counter != PRED_STRONG_NOT_TAKEN) begin
          table_q[wr_idx].counter <= wr_entry.counter - 2'd1;
        end
      end else if (upd_taken) begin
        // Allocate over whatever sat in this set
        table_q[wr_idx] <= '{valid: 1'b1, tag: wr_tag, target: upd_target,
                             counter: PRED_WEAK_TAKEN};
      end
    end
  end

endmodule

/* logic/icache.sv */
module icache #(
  parameter int ICACHE_LINES = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  cpu_pkg::pc_t                   pc,         // Word address to fetch
  fetch_if.fetch_src                     fetch,      // inst and hit
  output logic                           miss_busy,  // Holds the sequencer
  // Read address channel
  output logic [$bits(cpu_pkg::pc_t):0]  araddr,
  output logic                           arvalid,
  input  logic                           arready,
  // Read data channel
  input  logic [axi_pkg::AXI_DATA_W-1:0] rdata,
  input  axi_pkg::resp_t                 rresp,
  input  logic                           rvalid,
  output logic                           rready
);
  import cpu_pkg::*;
  import axi_pkg::*;

  localparam int IDX_W  = $clog2(ICACHE_LINES);
  localparam int TAG_W  = $bits(pc_t) - IDX_W;
  localparam int HALF_W = AXI_DATA_W / 2;

  typedef enum logic [1:0] {
    S_IDLE,  // Serving hits
    S_ADDR,  // arvalid up
    S_DATA   // Waiting on rvalid
  } state_t;

  state_t           state_q;
  pc_t              miss_pc_q;  // Address of the line being refilled
  prot_t            arprot;
  logic             valid_q [ICACHE_LINES];
  logic [TAG_W-1:0] tag_q [ICACHE_LINES];
  inst_t            data_q [ICACHE_LINES];
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] fill_idx;
  logic             hit;
  logic             fill;       // R handshake
  inst_t            fill_inst;

  //////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////
  assign rd_idx     = pc[IDX_W-1:0];
  assign hit        = valid_q[rd_idx] && (tag_q[rd_idx] == pc[IDX_W +: TAG_W]);
  assign fetch.hit  = hit;
  assign fetch.inst = data_q[rd_idx];
  assign miss_busy  = ~hit;

  //////////////////////////////////////////////////
  // AXI4-Lite refill
  //////////////////////////////////////////////////
  assign arvalid   = (state_q == S_ADDR);
  assign rready    = (state_q == S_DATA);  // Only with a read outstanding
  assign araddr    = {miss_pc_q, 1'b0};    // Word to byte address
  assign arprot    = AXI_PROT_INSN;
  assign fill      = rvalid & rready;
  assign fill_idx  = miss_pc_q[IDX_W-1:0];
  // Byte address bit 1 picks the half
  assign fill_inst = miss_pc_q[0] ? rdata[AXI_DATA_W-1:HALF_W] : rdata[HALF_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      miss_pc_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (!hit) begin
            miss_pc_q <= pc;  // Latched so a redirect cannot disturb araddr
            state_q   <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (arready) state_q <= S_DATA;
        end
        S_DATA: begin
          if (rvalid) state_q <= S_IDLE;  // Next lookup uses the live PC
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ICACHE_LINES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (fill) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[fill_idx]  <= miss_pc_q[IDX_W +: TAG_W];
      data_q[fill_idx] <= fill_inst;  // Error responses still fill
    end
  end

  // AR payload must not move while the slave is stalling
  a_ar_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arprot)
  ) else $error("AR payload changed before arready");

  a_resp_okay: assert property (
    @(posedge clk) disable iff (!rst_n)
    fill |-> rresp == RESP_OKAY
  ) else $error("Refill returned an error response and was cached anyway");

endmodule

/* logic/if_id_pipe_reg.sv */
module if_id_pipe_reg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,                // Decode cannot take a word
  input  logic           flush,                // Redirect kills the word in flight
  fetch_if.fetch_dst     fetch,
  output cpu_pkg::pc_t   id_pc_curr,
  output cpu_pkg::pc_t   id_pc_next,
  output cpu_pkg::inst_t id_inst,
  output logic           id_btb_match,
  output logic           id_icache_hit,        // Low marks a bubble
  output cpu_pkg::pred_t id_prediction,
  output cpu_pkg::pc_t   id_predicted_target
);
  import cpu_pkg::*;

  logic wen;  // Capture enable

  assign wen = ~stall;

  // PC pair survives a flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_pc_curr <= '0;
      id_pc_next <= '0;
    end else if (wen && !flush) begin
      id_pc_curr <= fetch.pc_curr;
      id_pc_next <= fetch.pc_next;
    end
  end

  // Word and prediction, cleared to a NOP bubble on flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_inst             <= NOP_INST;
      id_icache_hit       <= 1'b0;
      id_btb_match        <= 1'b0;
      id_prediction       <= PRED_STRONG_NOT_TAKEN;
      id_predicted_target <= '0;
    end else if (flush) begin
      id_inst             <= NOP_INST;  // Overrides the stall hold
      id_icache_hit       <= 1'b0;
      id_btb_match        <= 1'b0;
      id_prediction       <= PRED_STRONG_NOT_TAKEN;
      id_predicted_target <= '0;
    end else if (wen) begin
      id_inst             <= fetch.inst;
      id_icache_hit       <= fetch.hit;
      id_btb_match        <= fetch.btb_match;
      id_prediction       <= fetch.prediction;
      id_predicted_target <= fetch.predicted_target;
    end
  end

endmodule

/* logic/fetch_stage_top.sv */
module fetch_stage_top #(
  parameter int           ICACHE_LINES = 16,
  parameter int           BTB_ENTRIES  = 8,
  parameter cpu_pkg::pc_t RESET_PC     = '0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           stall,
  input  logic                           redirect_valid,
  input  cpu_pkg::pc_t                   redirect_pc,
  // Branch resolution from execute
  input  logic                           br_valid,
  input  cpu_pkg::pc_t                   br_pc,
  input  logic                           br_taken,
  input  cpu_pkg::pc_t                   br_target,
  // AXI4-Lite read master
  output logic [$bits(cpu_pkg::pc_t):0]  araddr,
  output logic                           arvalid,
  input  logic                           arready,
  input  logic [axi_pkg::AXI_DATA_W-1:0] rdata,
  input  axi_pkg::resp_t                 rresp,
  input  logic                           rvalid,
  output logic                           rready,
  // To decode
  output cpu_pkg::pc_t                   id_pc_curr,
  output cpu_pkg::pc_t                   id_pc_next,
  output cpu_pkg::inst_t                 id_inst,
  output logic                           id_btb_match,
  output logic                           id_icache_hit,
  output cpu_pkg::pred_t                 id_prediction,
  output cpu_pkg::pc_t                   id_predicted_target
);
  import cpu_pkg::*;

  pc_t  fetch_pc;   // Shared lookup address
  logic miss_busy;

  fetch_if fetch_bus ();

  //////////////////////////////////////////////////
  // Fetch blocks
  //////////////////////////////////////////////////
  pc_sequencer #(.RESET_PC(RESET_PC)) u_pc_seq (
    .clk, .rst_n, .stall, .miss_busy, .redirect_valid, .redirect_pc,
    .fetch (fetch_bus.fetch_src),
    .pc    (fetch_pc)
  );

  branch_target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
    .clk, .rst_n,
    .lookup_pc  (fetch_pc),
    .fetch      (fetch_bus.fetch_src),
    .upd_valid  (br_valid),
    .upd_pc     (br_pc),
    .upd_taken  (br_taken),
    .upd_target (br_target)
  );

  icache #(.ICACHE_LINES(ICACHE_LINES)) u_icache (
    .clk, .rst_n,
    .pc    (fetch_pc),
    .fetch (fetch_bus.fetch_src),
    .miss_busy,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready
  );

  if_id_pipe_reg u_if_id (
    .clk, .rst_n, .stall,
    .flush (redirect_valid),  // Wrong-path word dies here
    .fetch (fetch_bus.fetch_dst),
    .id_pc_curr, .id_pc_next, .id_inst, .id_btb_match,
    .id_icache_hit, .id_prediction, .id_predicted_target
  );

endmodule

/* include/fetch_mem.svh */
// Instruction memory contents as a fixed function of the word address
// Every address bit reaches the result, so aliasing lines give different words
function automatic logic [15:0] mem_word(input logic [15:0] pc);
  logic [15:0] mix;
  mix = pc * 16'h9e37;
  mem_word = mix ^ {pc[7:0], pc[15:8]} ^ 16'h3c5a;
endfunction

/* testbench/fetch_checker.sv */
module fetch_checker #(
  parameter int           BTB_ENTRIES = 8,
  parameter cpu_pkg::pc_t RESET_PC    = '0
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,
  input  logic           redirect_valid,
  input  cpu_pkg::pc_t   redirect_pc,
  input  logic           br_valid,
  input  cpu_pkg::pc_t   br_pc,
  input  logic           br_taken,
  input  cpu_pkg::pc_t   br_target,
  input  logic [16:0]    araddr,
  input  logic           arvalid,
  input  logic           arready,
  input  logic           rvalid,
  input  logic           rready,
  input  cpu_pkg::pc_t   id_pc_curr,
  input  cpu_pkg::pc_t   id_pc_next,
  input  cpu_pkg::inst_t id_inst,
  input  logic           id_btb_match,
  input  logic           id_icache_hit,
  input  cpu_pkg::pred_t id_prediction,
  input  cpu_pkg::pc_t   id_predicted_target,
  output int             error_count,
  output int             hits_seen,
  output logic           hang
);
  import cpu_pkg::*;

  `include "fetch_mem.svh"

  localparam int IDX_W      = $clog2(BTB_ENTRIES);
  localparam int HANG_LIMIT = 300;  // Cycles without a new hit

  // BTB model and the copy taken when a word was fetched
  logic  m_valid [BTB_ENTRIES];
  pc_t   m_tag [BTB_ENTRIES];
  pc_t   m_target [BTB_ENTRIES];
  pred_t m_cnt [BTB_ENTRIES];
  logic  s_valid [BTB_ENTRIES];
  pc_t   s_tag [BTB_ENTRIES];
  pc_t   s_target [BTB_ENTRIES];
  pred_t s_cnt [BTB_ENTRIES];

  logic [67:0] cur_out;
  logic [67:0] prev_out;
  logic        have_prev;
  logic        prev_stall;
  logic        prev_redirect;
  logic        prev_arvalid;
  logic        prev_arready;
  logic        outstanding;
  logic [16:0] prev_araddr;
  pc_t         exp_pc;     // Where the next new hit must be
  logic        exp_redir;  // Expectation came from a redirect
  int          idle;

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s at %0t: expected %h, actual %h", test, $time, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t: %s", $time, what);
    error_count++;
  endtask

  //////////////////////////////////////////////////
  // Compare on every rising edge
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    logic [IDX_W-1:0] idx;
    logic             e_match;
    pc_t              e_next;
    logic             new_hit;
    if (!rst_n) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_valid[i]  = 1'b0;
        m_tag[i]    = '0;
        m_target[i] = '0;
        m_cnt[i]    = '0;
      end
      have_prev     = 1'b0;
      prev_stall    = 1'b0;
      prev_redirect = 1'b0;
      prev_arvalid  = 1'b0;
      prev_arready  = 1'b0;
      outstanding   = 1'b0;
      prev_araddr   = '0;
      exp_pc = RESET_PC;
      exp_redir = 1'b0;
      idle = 0;
      error_count = 0;
      hits_seen = 0;
      hang = 1'b0;
    end else begin
      cur_out = {id_pc_curr, id_pc_next, id_inst, id_btb_match, id_icache_hit,
                 id_prediction, id_predicted_target};
      new_hit = id_icache_hit && have_prev && (!prev_stall || prev_redirect);

      // Stall hold and flush bubble
      if (have_prev && prev_stall && !prev_redirect && cur_out != prev_out)
        report_problem("IF/ID outputs changed while stalled");
      if (have_prev && prev_redirect && (id_icache_hit || id_inst != NOP_INST))
        report_mismatch("flush bubble", {15'd0, 1'b0, NOP_INST},
                        {15'd0, id_icache_hit, id_inst});

      if (id_icache_hit && id_inst != mem_word(id_pc_curr))
        report_mismatch("fetched data", 32'(mem_word(id_pc_curr)), 32'(id_inst));

      if (new_hit) begin
        hits_seen++;
        idx     = id_pc_curr[IDX_W-1:0];
        e_match = s_valid[idx] && s_tag[idx] == (id_pc_curr >> IDX_W);
        if (id_btb_match != e_match)
          report_mismatch("btb match", 32'(e_match), 32'(id_btb_match));
        if (id_prediction != (e_match ? s_cnt[idx] : 2'b00))
          report_mismatch("prediction", 32'(e_match ? s_cnt[idx] : 2'b00),
                          32'(id_prediction));
        if (id_predicted_target != (e_match ? s_target[idx] : 16'h0000))
          report_mismatch("predicted target", 32'(e_match ? s_target[idx] : 16'h0000),
                          32'(id_predicted_target));
        e_next = (e_match && s_cnt[idx][1]) ? s_target[idx] : id_pc_curr + 16'd1;
        if (id_pc_next != e_next)
          report_mismatch("next pc", 32'(e_next), 32'(id_pc_next));
        // Progress check also covers the first word after a redirect
        if (id_pc_curr != exp_pc)
          report_mismatch(exp_redir ? "flush target" : "pc sequence", 32'(exp_pc),
                          32'(id_pc_curr));
        exp_pc    = id_pc_next;
        exp_redir = 1'b0;
        idle      = 0;
      end else begin
        idle++;
        if (idle > HANG_LIMIT && !hang) begin
          report_problem("fetch hang, no new instruction delivered in time");
          hang = 1'b1;
        end
      end

      // Bus protocol
      if (prev_arvalid && !prev_arready && (!arvalid || araddr != prev_araddr))
        report_problem("arvalid dropped or araddr changed before arready");
      if (arvalid && outstanding)
        report_problem("second read address issued before the data handshake");
      if (rready && !outstanding)
        report_problem("rready high with no read outstanding");
      if (rvalid && rready) outstanding = 1'b0;
      if (arvalid && arready) outstanding = 1'b1;

      // Freeze the model for the word captured on this edge
      s_valid  = m_valid;
      s_tag    = m_tag;
      s_target = m_target;
      s_cnt    = m_cnt;
      if (redirect_valid) begin
        exp_pc    = redirect_pc;
        exp_redir = 1'b1;
      end

      //////////////////////////////////////////////////
      // BTB training
      //////////////////////////////////////////////////
      if (br_valid) begin
        idx = br_pc[IDX_W-1:0];
        if (m_valid[idx] && m_tag[idx] == (br_pc >> IDX_W)) begin
          if (br_taken) begin
            m_target[idx] = br_target;
            if (m_cnt[idx] != 2'b11) m_cnt[idx] = m_cnt[idx] + 2'd1;
          end else if (m_cnt[idx] != 2'b00) begin
            m_cnt[idx] = m_cnt[idx] - 2'd1;
          end
        end else if (br_taken) begin
          m_valid[idx]  = 1'b1;  // Fresh entry starts weakly taken
          m_tag[idx]    = br_pc >> IDX_W;
          m_target[idx] = br_target;
          m_cnt[idx]    = 2'b10;
        end
      end

      prev_out      = cur_out;
      prev_stall    = stall;
      prev_redirect = redirect_valid;
      prev_arvalid  = arvalid;
      prev_arready  = arready;
      prev_araddr   = araddr;
      have_prev     = 1'b1;
    end
  end

endmodule

/* testbench/tb_fetch.sv */
module tb_fetch;
  import cpu_pkg::*;
  import axi_pkg::*;

  `include "fetch_mem.svh"

  localparam int RUN_CYCLES = 3000;
  localparam int WAIT_LIMIT = RUN_CYCLES + 200;  // Idle bus may wait the whole run
  localparam int HS_LIMIT   = 64;                // Handshake must close quickly

  logic        clk;
  logic        rst_n;
  logic        stall;
  logic        redirect_valid;
  pc_t         redirect_pc;
  logic        br_valid;
  pc_t         br_pc;
  logic        br_taken;
  pc_t         br_target;
  logic [16:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [AXI_DATA_W-1:0] rdata;
  resp_t       rresp;
  logic        rvalid;
  logic        rready;
  pc_t         id_pc_curr;
  pc_t         id_pc_next;
  inst_t       id_inst;
  logic        id_btb_match;
  logic        id_icache_hit;
  pred_t       id_prediction;
  pc_t         id_predicted_target;
  int          error_count;
  int          hits_seen;
  logic        hang;
  logic        run_done;
  logic        bus_timeout;

  fetch_stage_top #(.ICACHE_LINES(16), .BTB_ENTRIES(8), .RESET_PC(16'h0000)) uut (.*);

  fetch_checker #(.BTB_ENTRIES(8), .RESET_PC(16'h0000)) chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Stimulus, driven on the falling edge
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h61a9_9043));
    rst_n          = 1'b0;
    stall          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    br_valid       = 1'b0;
    br_pc          = '0;
    br_taken       = 1'b0;
    br_target      = '0;
    run_done       = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    for (int cyc = 0; cyc < RUN_CYCLES && !hang && !bus_timeout; cyc++) begin
      @(negedge clk);
      stall          = ($urandom % 5) == 0;   // About 20% back-pressure
      redirect_valid = ($urandom % 25) == 0;
      redirect_pc    = 16'($urandom % 40);    // Small range keeps lines aliasing
      br_valid       = ($urandom % 4) == 0;
      br_pc          = 16'($urandom % 40);
      br_taken       = 1'($urandom % 2);
      br_target      = 16'($urandom % 40);
    end
    @(negedge clk);
    stall          = 1'b0;
    redirect_valid = 1'b0;
    br_valid       = 1'b0;
    run_done       = 1'b1;
    repeat (2) @(negedge clk);
    $display("Run over: %0d errors, %0d new hits checked", error_count, hits_seen);
    if (error_count == 0 && !hang && !bus_timeout) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // AXI4-Lite read slave with random latency
  //////////////////////////////////////////////////
  initial begin
    int          waited;
    int          delay;
    logic [15:0] word;
    logic [15:0] base;
    arready     = 1'b0;
    rdata       = '0;
    rresp       = RESP_OKAY;
    rvalid      = 1'b0;
    bus_timeout = 1'b0;
    @(posedge rst_n);
    while (!run_done && !bus_timeout) begin
      waited = 0;
      @(negedge clk);
      while (!arvalid && !run_done && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (waited >= WAIT_LIMIT) begin
        $display("Timeout: no read address request arrived");
        bus_timeout = 1'b1;
      end else if (arvalid && !run_done) begin
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        word    = araddr[16:1];  // Byte address back to word address
        arready = 1'b1;
        waited  = 0;
        // arvalid is already up, so AR closes on the next rising edge
        do begin
          @(negedge clk);
          waited++;
        end while (arvalid && waited < HS_LIMIT);
        arready = 1'b0;
        if (waited >= HS_LIMIT) begin
          $display("Timeout: read address was never accepted");
          bus_timeout = 1'b1;
        end
        delay = $urandom % 5;
        repeat (delay) @(negedge clk);
        base   = {word[15:1], 1'b0};
        rdata  = {mem_word(base | 16'h0001), mem_word(base)};  // Odd word in the high half
        rresp  = RESP_OKAY;
        rvalid = 1'b1;
        waited = 0;
        while (!rready && waited < HS_LIMIT) begin
          @(negedge clk);
          waited++;
        end
        if (waited >= HS_LIMIT) begin
          $display("Timeout: rready never rose for an outstanding read");
          bus_timeout = 1'b1;
        end
        @(negedge clk);  // R beat taken on the rising edge in between
        rvalid = 1'b0;
      end
    end
  end

endmodule

/* vlog.f */
+incdir+include
logic/cpu_pkg.sv
logic/axi_pkg.sv
logic/fetch_if.sv
logic/pc_sequencer.sv
logic/branch_target_buffer.sv
logic/icache.sv
logic/if_id_pipe_reg.sv
logic/fetch_stage_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_fetch
RTL_TOP    ?= fetch_stage_top
FILELIST   ?= vlog.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir
